// ==== hw/vic_pkg.sv ====
/*
	VIC I/O core shared definitions
	Data and address widths, timing PROM download map, status overlay
	bit positions and the two-way view of the I/O port address byte
*/

`default_nettype none

package vic_pkg;

	// CPU data byte, also PROM words and download data
	typedef logic [7:0] data_t;
	// Download address
	typedef logic [15:0] dn_addr_t;
	// Timing PROM entry address
	typedef logic [4:0] prom_addr_t;

	// Timing PROM download windows
	localparam dn_addr_t PROM_CTL_BASE = 16'h1C20;
	localparam dn_addr_t PROM_SEQ_BASE = 16'h1C40;
	localparam int PROM_SIZE = 32;

	// Control word SRC bit, rising edge gives pixel enable
	localparam int CTL_SRC_BIT = 5;
	// Sequence word PHI bit, rising edge gives CPU enable
	localparam int SEQ_PHI_BIT = 1;

	// Status overlay bits, standard decode boards (port 4 only)
	localparam int STATUS_P4_COIN_STD = 7;
	localparam int STATUS_P4_TIMER_STD = 0;
	// Status overlay bits, alternate decode boards
	localparam int STATUS_COIN_ALT = 3;
	localparam int STATUS_TIMER_ALT = 3;

	// I/O port address, one-hot selects or 2-bit port index
	typedef union packed {
		logic [7:0] onehot;
		struct packed {
			logic [5:0] unused;
			logic [1:0] index;
		} idx;
	} port_addr_u;

	// Output latch idle value
	localparam data_t PORT_IDLE = 8'hFF;

endpackage

`default_nettype wire

// ==== hw/timing_prom.sv ====
/*
	Timing PROM
	32 x 8 bipolar PROM stand-in, loaded through the download port
	and read one clock after the address is presented
*/

`timescale 1ns/1ns
`default_nettype none

module timing_prom (
	input  wire logic               clk,
	input  wire logic               wr,
	input  wire vic_pkg::prom_addr_t wr_addr,
	input  wire vic_pkg::data_t      wr_data,
	input  wire vic_pkg::prom_addr_t rd_addr,
	output vic_pkg::data_t          rd_data
);

	// PROM contents
	vic_pkg::data_t mem [vic_pkg::PROM_SIZE];

	// Download write port
	always_ff @(posedge clk)
	begin
		if (wr)
			mem[wr_addr] <= wr_data;
	end

	// Registered read, acts as the PROM output latch
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== hw/timing_sequencer.sv ====
/*
	Timing sequencer
	Walks the control PROM as a next-state table, with the sequence PROM
	read in step. Rising edges of the SRC and PHI bits, found against the
	latched previous words, give the pixel and CPU clock enables
*/

`timescale 1ns/1ns
`default_nettype none

module timing_sequencer (
	input  wire logic             clk,
	input  wire logic             reset,
	input  wire logic             dn_download,
	input  wire logic             dn_wr,
	input  wire vic_pkg::dn_addr_t dn_addr,
	input  wire vic_pkg::data_t    dn_data,
	output logic                  cpu_en,
	output logic                  ce_pix
);

	logic held;
	vic_pkg::dn_addr_t ctl_off;
	vic_pkg::dn_addr_t seq_off;
	logic ctl_wr;
	logic seq_wr;
	vic_pkg::prom_addr_t prom_addr;
	vic_pkg::data_t ctl_word;
	vic_pkg::data_t seq_word;
	vic_pkg::data_t ctl_prev;
	vic_pkg::data_t seq_prev;

	// Sequencer stalls during reset and while PROMs load
	assign held = reset | dn_download;

	// ------------------------------------------------------------------------
	// Download decode
	// ------------------------------------------------------------------------

	// Offsets wrap below the base so one compare covers each window
	assign ctl_off = dn_addr - vic_pkg::PROM_CTL_BASE;
	assign seq_off = dn_addr - vic_pkg::PROM_SEQ_BASE;
	assign ctl_wr = dn_wr && (ctl_off < vic_pkg::dn_addr_t'(vic_pkg::PROM_SIZE));
	assign seq_wr = dn_wr && (seq_off < vic_pkg::dn_addr_t'(vic_pkg::PROM_SIZE));

	// ------------------------------------------------------------------------
	// PROMs and address feedback
	// ------------------------------------------------------------------------

	// Control word low bits are the next step address
	assign prom_addr = held ? '0 : ctl_word[4:0];

	// Control PROM
	timing_prom u_ctl_prom (
		.clk     (clk),
		.wr      (ctl_wr),
		.wr_addr (vic_pkg::prom_addr_t'(ctl_off)),
		.wr_data (dn_data),
		.rd_addr (prom_addr),
		.rd_data (ctl_word)
	);

	// Sequence PROM
	timing_prom u_seq_prom (
		.clk     (clk),
		.wr      (seq_wr),
		.wr_addr (vic_pkg::prom_addr_t'(seq_off)),
		.wr_data (dn_data),
		.rd_addr (prom_addr),
		.rd_data (seq_word)
	);

	// Previous words are zero on the first step after release
	always_ff @(posedge clk)
	begin
		if (held)
		begin
			ctl_prev <= '0;
			seq_prev <= '0;
		end
		else
		begin
			ctl_prev <= ctl_word;
			seq_prev <= seq_word;
		end
	end

	// Enable pulses on rising SRC and PHI bits
	// Quiet while held
	assign ce_pix = ~held & ctl_word[vic_pkg::CTL_SRC_BIT] & ~ctl_prev[vic_pkg::CTL_SRC_BIT];
	assign cpu_en = ~held & seq_word[vic_pkg::SEQ_PHI_BIT] & ~seq_prev[vic_pkg::SEQ_PHI_BIT];

	// Latched previous word ends each enable after one clock
	a_pix_one_clock: assert property (
		@(posedge clk) ce_pix |=> !ce_pix
	);
	a_cpu_one_clock: assert property (
		@(posedge clk) cpu_en |=> !cpu_en
	);

endmodule

`default_nettype wire

// ==== hw/io_ports.sv ====
/*
	CPU I/O ports
	Input port select in standard (one-hot) or alternate (indexed) decode,
	registered port data with timer and coin latch status overlaid,
	and the four output latches loaded on rising write selects
*/

`timescale 1ns/1ns
`default_nettype none

module io_ports #(
	parameter bit ALT_DECODE = 1'b0
) (
	input  wire logic          clk,
	input  wire logic          reset,
	input  wire logic          io_rd,
	input  wire logic          io_wr,
	input  wire vic_pkg::data_t io_addr,
	input  wire vic_pkg::data_t cpu_wdata,
	input  wire vic_pkg::data_t in_p1,
	input  wire vic_pkg::data_t in_p2,
	input  wire vic_pkg::data_t in_p3,
	input  wire vic_pkg::data_t in_p4,
	input  wire logic          coin_latch_active,
	input  wire logic          timer_level,
	output vic_pkg::data_t     cpu_rdata,
	output vic_pkg::data_t     out_p1_data,
	output vic_pkg::data_t     out_p2_data,
	output vic_pkg::data_t     out_p3_data,
	output vic_pkg::data_t     out_p4_data,
	output logic               p4_read
);

	vic_pkg::port_addr_u addr_v;
	logic [3:0] rd_dec;
	logic [3:0] rd_next;
	logic [3:0] rd_sel_q;
	logic [3:0] wr_sel;
	logic [3:0] wr_sel_q;
	logic [3:0] wr_rise_q;
	vic_pkg::data_t port_ovl [4];
	vic_pkg::data_t port_q [4];
	vic_pkg::data_t out_q [4];

	assign addr_v = io_addr;

	// ------------------------------------------------------------------------
	// Input side
	// ------------------------------------------------------------------------

	// Read decode; standard boards give port 1 priority
	always_comb
	begin
		rd_dec = '0;
		if (ALT_DECODE)
			rd_dec[addr_v.idx.index] = 1'b1;
		else
		begin
			for (int i = 3; i >= 0; i--)
			begin
				if (addr_v.onehot[i])
					rd_dec = 4'b0001 << i;
			end
		end
	end
	assign rd_next = io_rd ? rd_dec : 4'b0000;

	// Status overlay, positions depend on board style
	always_comb
	begin
		port_ovl[0] = in_p1;
		port_ovl[1] = in_p2;
		port_ovl[2] = in_p3;
		port_ovl[3] = in_p4;
		if (ALT_DECODE)
		begin
			port_ovl[3][vic_pkg::STATUS_COIN_ALT] = ~coin_latch_active;
			port_ovl[2][vic_pkg::STATUS_TIMER_ALT] = timer_level;
		end
		else
		begin
			port_ovl[3][vic_pkg::STATUS_P4_COIN_STD] = ~coin_latch_active;
			port_ovl[3][vic_pkg::STATUS_P4_TIMER_STD] = timer_level;
		end
	end

	// Select and p4 read strobe
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_sel_q <= '0;
			p4_read <= 1'b0;
		end
		else
		begin
			rd_sel_q <= rd_next;
			// High in the first cycle the registered port 4 select is set
			p4_read <= rd_next[3] & ~rd_sel_q[3];
		end
	end

	// Port data capture
	always_ff @(posedge clk)
	begin
		port_q <= port_ovl;
	end

	// Read mux, zero when nothing selected
	always_comb
	begin
		cpu_rdata = '0;
		for (int i = 3; i >= 0; i--)
		begin
			if (rd_sel_q[i])
				cpu_rdata = port_q[i];
		end
	end

	a_rd_sel_onehot: assert property (
		@(posedge clk) disable iff (reset) $onehot0(rd_sel_q)
	);

	// ------------------------------------------------------------------------
	// Output side
	// ------------------------------------------------------------------------

	// Output ports always one-hot
	assign wr_sel = io_wr ? addr_v.onehot[3:0] : 4'b0000;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_sel_q <= '0;
			wr_rise_q <= '0;
			for (int i = 0; i < 4; i++)
				out_q[i] <= vic_pkg::PORT_IDLE;
		end
		else
		begin
			wr_sel_q <= wr_sel;
			wr_rise_q <= wr_sel & ~wr_sel_q;
			// CPU holds write data across the strobe
			for (int i = 0; i < 4; i++)
			begin
				if (wr_rise_q[i])
					out_q[i] <= cpu_wdata;
			end
		end
	end

	assign out_p1_data = out_q[0];
	assign out_p2_data = out_q[1];
	assign out_p3_data = out_q[2];
	assign out_p4_data = out_q[3];

endmodule

`default_nettype wire

// ==== hw/coin_timer.sv ====
/*
	Coin and timer circuit
	Coin edge holds the CPU in reset for a while, then arms a latch that
	the game sees on port 4 and counts down one step per port 4 read.
	Also the free-running status timer square wave
*/

`timescale 1ns/1ns
`default_nettype none

module coin_timer #(
	parameter int COIN_START_CYCLES = 63,
	parameter int COIN_LATCH_CYCLES = 1023,
	parameter int TIMER_PERIOD = 19500
) (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic coin,
	input  wire logic p4_read,
	output logic      cpu_reset,
	output logic      coin_latch_active,
	output logic      timer_level
);

	localparam int START_W = $clog2(COIN_START_CYCLES + 1);
	localparam int LATCH_W = $clog2(COIN_LATCH_CYCLES + 1);
	localparam int TIMER_W = $clog2(TIMER_PERIOD + 1);

	logic coin_last;
	logic coin_rise;
	logic pending;
	logic [START_W-1:0] start_cnt;
	logic [LATCH_W-1:0] latch_cnt;
	logic [TIMER_W-1:0] timer_cnt;

	assign coin_rise = coin & ~coin_last;

	// ------------------------------------------------------------------------
	// Coin start pulse and latch
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			coin_last <= 1'b0;
			pending <= 1'b0;
			start_cnt <= '0;
			latch_cnt <= '0;
		end
		else
		begin
			coin_last <= coin;

			// Reset pulse countdown
			if (coin_rise)
				start_cnt <= START_W'(COIN_START_CYCLES);
			else if (start_cnt != '0)
				start_cnt <= start_cnt - 1'b1;

			// Latch only arms once the CPU is out of reset and polls port 4
			if (p4_read)
			begin
				if (pending && start_cnt == '0)
				begin
					latch_cnt <= LATCH_W'(COIN_LATCH_CYCLES);
					pending <= 1'b0;
				end
				else if (latch_cnt != '0)
					latch_cnt <= latch_cnt - 1'b1;
			end

			// New coin wins over a same-cycle arm
			if (coin_rise)
				pending <= 1'b1;
		end
	end

	assign cpu_reset = reset | (start_cnt != '0);
	assign coin_latch_active = (latch_cnt != '0);

	a_latch_bound: assert property (
		@(posedge clk) disable iff (reset) latch_cnt <= LATCH_W'(COIN_LATCH_CYCLES)
	);

	// ------------------------------------------------------------------------
	// Status timer
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			timer_cnt <= '0;
			timer_level <= 1'b1;
		end
		else if (timer_cnt == TIMER_W'(TIMER_PERIOD - 1))
		begin
			timer_cnt <= '0;
			timer_level <= ~timer_level;
		end
		else
			timer_cnt <= timer_cnt + 1'b1;
	end

endmodule

`default_nettype wire

// ==== hw/vic_io_top.sv ====
/*
	VIC I/O and timing core
	Timing sequencer, CPU port block and coin/timer circuit;
	the CPU itself sits outside on the I/O bus
*/

`timescale 1ns/1ns
`default_nettype none

module vic_io_top #(
	parameter bit ALT_DECODE = 1'b0,
	parameter int COIN_START_CYCLES = 63,
	parameter int COIN_LATCH_CYCLES = 1023,
	parameter int TIMER_PERIOD = 19500
) (
	input  wire logic             clk,
	input  wire logic             reset,
	// CPU I/O bus
	input  wire logic             io_rd,
	input  wire logic             io_wr,
	input  wire vic_pkg::data_t    io_addr,
	input  wire vic_pkg::data_t    cpu_wdata,
	output vic_pkg::data_t        cpu_rdata,
	// Cabinet inputs and outputs
	input  wire vic_pkg::data_t    in_p1,
	input  wire vic_pkg::data_t    in_p2,
	input  wire vic_pkg::data_t    in_p3,
	input  wire vic_pkg::data_t    in_p4,
	input  wire logic             coin,
	output vic_pkg::data_t        out_p1_data,
	output vic_pkg::data_t        out_p2_data,
	output vic_pkg::data_t        out_p3_data,
	output vic_pkg::data_t        out_p4_data,
	// Download port
	input  wire logic             dn_download,
	input  wire logic             dn_wr,
	input  wire vic_pkg::dn_addr_t dn_addr,
	input  wire vic_pkg::data_t    dn_data,
	// Clock enables and CPU reset
	output logic                  cpu_en,
	output logic                  ce_pix,
	output logic                  cpu_reset
);

	logic p4_read;
	logic coin_latch_active;
	logic timer_level;

	timing_sequencer u_seq (
		.clk         (clk),
		.reset       (reset),
		.dn_download (dn_download),
		.dn_wr       (dn_wr),
		.dn_addr     (dn_addr),
		.dn_data     (dn_data),
		.cpu_en      (cpu_en),
		.ce_pix      (ce_pix)
	);

	io_ports #(
		.ALT_DECODE (ALT_DECODE)
	) u_ports (
		.clk               (clk),
		.reset             (reset),
		.io_rd             (io_rd),
		.io_wr             (io_wr),
		.io_addr           (io_addr),
		.cpu_wdata         (cpu_wdata),
		.in_p1             (in_p1),
		.in_p2             (in_p2),
		.in_p3             (in_p3),
		.in_p4             (in_p4),
		.coin_latch_active (coin_latch_active),
		.timer_level       (timer_level),
		.cpu_rdata         (cpu_rdata),
		.out_p1_data       (out_p1_data),
		.out_p2_data       (out_p2_data),
		.out_p3_data       (out_p3_data),
		.out_p4_data       (out_p4_data),
		.p4_read           (p4_read)
	);

	coin_timer #(
		.COIN_START_CYCLES (COIN_START_CYCLES),
		.COIN_LATCH_CYCLES (COIN_LATCH_CYCLES),
		.TIMER_PERIOD      (TIMER_PERIOD)
	) u_coin (
		.clk               (clk),
		.reset             (reset),
		.coin              (coin),
		.p4_read           (p4_read),
		.cpu_reset         (cpu_reset),
		.coin_latch_active (coin_latch_active),
		.timer_level       (timer_level)
	);

endmodule

`default_nettype wire

// ==== verif/tb_vic_io_model.svh ====
/*
	VIC I/O testbench model
	LFSR stimulus source, reference state for the PROMs, port registers,
	latches and counters, and the typed compare tasks
*/

`ifndef TB_VIC_IO_MODEL_SVH
`define TB_VIC_IO_MODEL_SVH

// ---------------------------------------------------------------------------
// Stimulus source
// ---------------------------------------------------------------------------

// 16-bit Fibonacci LFSR, taps 16 14 13 11
logic [15:0] lfsr_state = 16'd8962;

function automatic logic [15:0] lfsr_step(input logic [15:0] state);
	return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

// One LFSR step per bit handed out
function automatic logic [31:0] rand_bits(input int count);
	logic [31:0] bits;
	bits = '0;
	for (int i = 0; i < count; i++)
	begin
		lfsr_state = lfsr_step(lfsr_state);
		bits = {bits[30:0], lfsr_state[0]};
	end
	return bits;
endfunction

// ---------------------------------------------------------------------------
// Reference state
// ---------------------------------------------------------------------------

// Mirrors of both timing PROMs
vic_pkg::data_t ctl_mem [vic_pkg::PROM_SIZE];
vic_pkg::data_t seq_mem [vic_pkg::PROM_SIZE];
// Sequencer walk, address of the current words
vic_pkg::prom_addr_t ref_addr;
vic_pkg::data_t ref_ctl_prev;
vic_pkg::data_t ref_seq_prev;
// Read data for this cycle, port 4 select history
vic_pkg::data_t ref_rdata;
logic ref_sel4;
logic ref_p4_read;
// Write select history and output latches
logic [3:0] ref_wsel;
logic [3:0] ref_wrise;
vic_pkg::data_t ref_out [4];
// Coin circuit counters
logic ref_coin_last;
logic ref_pending;
int ref_start;
int ref_latch;
// Clocks since reset, drives the timer level
int ref_run_cycles;

// High for the first period, then flips once per period
function automatic logic timer_expected(input int cycles);
	return ((cycles / TIMER_PERIOD) % 2) == 0;
endfunction

// Port bytes
task automatic check_data(input string name, input vic_pkg::data_t got,
	input vic_pkg::data_t exp);
	if (got !== exp)
		report_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

// Clock enable pulses
task automatic check_pulse(input string name, input logic got, input logic exp);
	if (got !== exp)
		report_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

// CPU reset and status levels
task automatic check_status(input string name, input logic got, input logic exp);
	if (got !== exp)
		report_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

`endif

// ==== verif/tb_vic_io.sv ====
/*
	VIC I/O core testbench
	PROM loads, random port reads and writes and a coin pulse, with every
	output compared each cycle against a cycle model of the core
*/

`timescale 1ns/1ns
`default_nettype none

module tb_vic_io;

	localparam bit ALT_DECODE = 1'b1;
	localparam int COIN_START_CYCLES = 6;
	localparam int COIN_LATCH_CYCLES = 5;
	localparam int TIMER_PERIOD = 40;
	// Longest any single wait may take in cycles
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic reset;
	logic io_rd;
	logic io_wr;
	vic_pkg::data_t io_addr;
	vic_pkg::data_t cpu_wdata;
	vic_pkg::data_t cpu_rdata;
	vic_pkg::data_t in_p1;
	vic_pkg::data_t in_p2;
	vic_pkg::data_t in_p3;
	vic_pkg::data_t in_p4;
	logic coin;
	vic_pkg::data_t out_p1_data;
	vic_pkg::data_t out_p2_data;
	vic_pkg::data_t out_p3_data;
	vic_pkg::data_t out_p4_data;
	logic dn_download;
	logic dn_wr;
	vic_pkg::dn_addr_t dn_addr;
	vic_pkg::data_t dn_data;
	logic cpu_en;
	logic ce_pix;
	logic cpu_reset;
	logic checking;

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1, "run stopped");
	endtask

	`include "tb_vic_io_model.svh"

	vic_io_top #(
		.ALT_DECODE        (ALT_DECODE),
		.COIN_START_CYCLES (COIN_START_CYCLES),
		.COIN_LATCH_CYCLES (COIN_LATCH_CYCLES),
		.TIMER_PERIOD      (TIMER_PERIOD)
	) i_dut (
		.clk         (clk),
		.reset       (reset),
		.io_rd       (io_rd),
		.io_wr       (io_wr),
		.io_addr     (io_addr),
		.cpu_wdata   (cpu_wdata),
		.cpu_rdata   (cpu_rdata),
		.in_p1       (in_p1),
		.in_p2       (in_p2),
		.in_p3       (in_p3),
		.in_p4       (in_p4),
		.coin        (coin),
		.out_p1_data (out_p1_data),
		.out_p2_data (out_p2_data),
		.out_p3_data (out_p3_data),
		.out_p4_data (out_p4_data),
		.dn_download (dn_download),
		.dn_wr       (dn_wr),
		.dn_addr     (dn_addr),
		.dn_data     (dn_data),
		.cpu_en      (cpu_en),
		.ce_pix      (ce_pix),
		.cpu_reset   (cpu_reset)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Whole-run watchdog
	initial
	begin
		#100000;
		report_failure("simulation ran past its time limit");
	end

	// ------------------------------------------------------------------------
	// Reference model stepping once per clock on the ending cycle's inputs
	// ------------------------------------------------------------------------
	task automatic model_step();
		vic_pkg::data_t port_val;
		vic_pkg::dn_addr_t ctl_off;
		vic_pkg::dn_addr_t seq_off;
		logic [1:0] port_idx;
		logic [3:0] wsel_now;
		logic coin_rise;
		// Alternate boards pick the port by index
		// Status bits come from this cycle
		port_idx = io_addr[1:0];
		case (port_idx)
			2'd0: port_val = in_p1;
			2'd1: port_val = in_p2;
			2'd2: port_val = in_p3;
			default: port_val = in_p4;
		endcase
		if (port_idx == 2'd3)
			port_val[vic_pkg::STATUS_COIN_ALT] = (ref_latch == 0);
		if (port_idx == 2'd2)
			port_val[vic_pkg::STATUS_TIMER_ALT] = timer_expected(ref_run_cycles);
		if (reset)
		begin
			ref_rdata = '0;
			ref_sel4 = 1'b0;
			ref_p4_read = 1'b0;
			ref_wsel = '0;
			ref_wrise = '0;
			for (int i = 0; i < 4; i++)
				ref_out[i] = vic_pkg::PORT_IDLE;
			ref_coin_last = 1'b0;
			ref_pending = 1'b0;
			ref_start = 0;
			ref_latch = 0;
			ref_run_cycles = 0;
		end
		else
		begin
			ref_rdata = io_rd ? port_val : '0;
			// Latch steps on this cycle's p4 read strobe
			coin_rise = coin && !ref_coin_last;
			if (ref_p4_read)
			begin
				if (ref_pending && ref_start == 0)
				begin
					ref_latch = COIN_LATCH_CYCLES;
					ref_pending = 1'b0;
				end
				else if (ref_latch > 0)
					ref_latch--;
			end
			if (coin_rise)
			begin
				ref_start = COIN_START_CYCLES;
				ref_pending = 1'b1;
			end
			else if (ref_start > 0)
				ref_start--;
			ref_coin_last = coin;
			ref_p4_read = io_rd && port_idx == 2'd3 && !ref_sel4;
			ref_sel4 = io_rd && port_idx == 2'd3;
			// Latch takes the data present one cycle after the select rises
			for (int i = 0; i < 4; i++)
			begin
				if (ref_wrise[i])
					ref_out[i] = cpu_wdata;
			end
			wsel_now = io_wr ? io_addr[3:0] : 4'b0000;
			ref_wrise = wsel_now & ~ref_wsel;
			ref_wsel = wsel_now;
			ref_run_cycles++;
		end
		// Address walk restarts from entry 0 after any hold
		if (reset || dn_download)
		begin
			ref_addr = '0;
			ref_ctl_prev = '0;
			ref_seq_prev = '0;
		end
		else
		begin
			ref_ctl_prev = ctl_mem[ref_addr];
			ref_seq_prev = seq_mem[ref_addr];
			ref_addr = ctl_mem[ref_addr][4:0];
		end
		ctl_off = dn_addr - vic_pkg::PROM_CTL_BASE;
		seq_off = dn_addr - vic_pkg::PROM_SEQ_BASE;
		if (dn_wr && int'(ctl_off) < vic_pkg::PROM_SIZE)
			ctl_mem[ctl_off[4:0]] = dn_data;
		if (dn_wr && int'(seq_off) < vic_pkg::PROM_SIZE)
			seq_mem[seq_off[4:0]] = dn_data;
	endtask

	always @(posedge clk)
	begin
		model_step();
	end

	// Outputs settle by the falling edge
	always @(negedge clk)
	begin
		if (checking)
		begin
			check_data("cpu_rdata", cpu_rdata, ref_rdata);
			check_data("out_p1_data", out_p1_data, ref_out[0]);
			check_data("out_p2_data", out_p2_data, ref_out[1]);
			check_data("out_p3_data", out_p3_data, ref_out[2]);
			check_data("out_p4_data", out_p4_data, ref_out[3]);
			check_status("cpu_reset", cpu_reset, reset || (ref_start != 0));
			if (reset || dn_download)
			begin
				check_pulse("ce_pix", ce_pix, 1'b0);
				check_pulse("cpu_en", cpu_en, 1'b0);
			end
			else
			begin
				check_pulse("ce_pix", ce_pix, ctl_mem[ref_addr][vic_pkg::CTL_SRC_BIT]
					& ~ref_ctl_prev[vic_pkg::CTL_SRC_BIT]);
				check_pulse("cpu_en", cpu_en, seq_mem[ref_addr][vic_pkg::SEQ_PHI_BIT]
					& ~ref_seq_prev[vic_pkg::SEQ_PHI_BIT]);
			end
		end
	end

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------

	// Control window first and the sequence window after it
	// Entry 0 of each goes in early
	task automatic load_proms();
		for (int i = 0; i < 2 * vic_pkg::PROM_SIZE; i++)
		begin
			@(posedge clk);
			dn_wr <= 1'b1;
			if (i < vic_pkg::PROM_SIZE)
				dn_addr <= vic_pkg::PROM_CTL_BASE + vic_pkg::dn_addr_t'(i);
			else
				dn_addr <= vic_pkg::PROM_SEQ_BASE
					+ vic_pkg::dn_addr_t'(i - vic_pkg::PROM_SIZE);
			dn_data <= vic_pkg::data_t'(rand_bits(8));
		end
		@(posedge clk);
		dn_wr <= 1'b0;
		repeat (2) @(posedge clk);
		dn_download <= 1'b0;
	endtask

	// Reads of 1 to 4 cycles with cabinet inputs changing every cycle
	task automatic random_reads(input int count);
		int len;
		vic_pkg::data_t addr;
		for (int r = 0; r < count; r++)
		begin
			len = 1 + int'(rand_bits(2));
			addr = vic_pkg::data_t'(rand_bits(8));
			for (int c = 0; c < len; c++)
			begin
				@(posedge clk);
				io_rd <= 1'b1;
				io_addr <= addr;
				in_p1 <= vic_pkg::data_t'(rand_bits(8));
				in_p2 <= vic_pkg::data_t'(rand_bits(8));
				in_p3 <= vic_pkg::data_t'(rand_bits(8));
				in_p4 <= vic_pkg::data_t'(rand_bits(8));
			end
			@(posedge clk);
			io_rd <= 1'b0;
		end
	endtask

	// Two-cycle write strobes with data held and at least one select bit
	task automatic random_writes(input int count);
		logic [3:0] sel;
		logic [3:0] upper;
		for (int w = 0; w < count; w++)
		begin
			sel = 4'(rand_bits(4));
			if (sel == 4'b0000)
				sel = 4'b0001 << rand_bits(2);
			upper = 4'(rand_bits(4));
			@(posedge clk);
			io_wr <= 1'b1;
			io_addr <= {upper, sel};
			cpu_wdata <= vic_pkg::data_t'(rand_bits(8));
			repeat (2) @(posedge clk);
			io_wr <= 1'b0;
		end
	endtask

	// One coin cycle and then the length of the CPU hold
	task automatic measure_coin_start();
		int high_cycles;
		@(posedge clk);
		coin <= 1'b1;
		@(negedge clk);
		check_status("cpu_reset", cpu_reset, 1'b0);
		@(posedge clk);
		coin <= 1'b0;
		@(negedge clk);
		high_cycles = 0;
		while (cpu_reset)
		begin
			high_cycles++;
			if (high_cycles > WAIT_LIMIT)
				report_failure("cpu_reset stayed high after the coin pulse");
			@(negedge clk);
		end
		check_data("cpu_reset length", vic_pkg::data_t'(high_cycles),
			vic_pkg::data_t'(COIN_START_CYCLES));
	endtask

	// Two-cycle port 4 read with the coin bit sampled in the second cycle
	task automatic read_port4(output logic coin_bit);
		logic [5:0] upper;
		upper = 6'(rand_bits(6));
		@(posedge clk);
		io_rd <= 1'b1;
		io_addr <= {upper, 2'b11};
		in_p4 <= vic_pkg::data_t'(rand_bits(8));
		@(posedge clk);
		@(negedge clk);
		coin_bit = cpu_rdata[vic_pkg::STATUS_COIN_ALT];
		@(posedge clk);
		io_rd <= 1'b0;
	endtask

	// Latch shows active on exactly COIN_LATCH_CYCLES reads
	task automatic count_latch_reads();
		logic coin_bit;
		logic seen_active;
		logic done;
		int active_reads;
		int reads;
		seen_active = 1'b0;
		done = 1'b0;
		active_reads = 0;
		reads = 0;
		while (!done)
		begin
			read_port4(coin_bit);
			reads++;
			if (!coin_bit)
			begin
				active_reads++;
				seen_active = 1'b1;
			end
			else if (seen_active)
				done = 1'b1;
			if (!done && reads > WAIT_LIMIT)
				report_failure("coin latch never cleared on port 4 reads");
		end
		check_data("coin latch reads", vic_pkg::data_t'(active_reads),
			vic_pkg::data_t'(COIN_LATCH_CYCLES));
	endtask

	initial
	begin
		reset = 1'b1;
		io_rd = 1'b0;
		io_wr = 1'b0;
		io_addr = '0;
		cpu_wdata = '0;
		in_p1 = '0;
		in_p2 = '0;
		in_p3 = '0;
		in_p4 = '0;
		coin = 1'b0;
		dn_download = 1'b1;
		dn_wr = 1'b0;
		dn_addr = '0;
		dn_data = '0;
		checking = 1'b0;
		@(posedge clk);
		checking <= 1'b1;
		@(posedge clk);
		reset <= 1'b0;
		load_proms();
		// Sequencer runs free from here and is checked every cycle
		repeat (100) @(posedge clk);
		random_reads(200);
		random_writes(60);
		measure_coin_start();
		count_latch_reads();
		repeat (10) @(posedge clk);
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verif
hw/vic_pkg.sv
hw/timing_prom.sv
hw/timing_sequencer.sv
hw/io_ports.sv
hw/coin_timer.sv
hw/vic_io_top.sv
verif/tb_vic_io.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the VIC I/O core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
	--top-module tb_vic_io -Mdir obj_dir -f flist.f
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status"
	exit 1
fi

./obj_dir/Vtb_vic_io
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit 1
fi

echo "simulation passed"
exit 0
